//--- src/rv_pkg.sv
// rv64 register and instruction types, field positions, pc step
package rv_pkg;

    // ********************
    // data path widths
    // ********************

    localparam int XLEN = 64;                    // integer register width

    typedef logic [XLEN-1:0] xword_t;            // register value or address
    typedef logic [31:0]     inst_t;             // one uncompressed instruction
    typedef logic [4:0]      reg_idx_t;          // x0 .. x31

    // ********************
    // instruction fields
    // ********************

    // low bit of each register field in the 32-bit encoding
    localparam int RD_LSB  = 7;                  // rd sits in [11:7]
    localparam int RS2_LSB = 20;                 // rs2 sits in [24:20]

    // link value for jal / jalr
    localparam xword_t INST_STEP = 64'd4;

endpackage

//--- src/mem_stage_pkg.sv
// memory stage operation codes, data ram geometry, byte lane types
package mem_stage_pkg;

    // ********************
    // operation codes
    // ********************

    typedef logic [3:0] mem_op_t;

    localparam mem_op_t OP_NONE = 4'd0;          // bubble, nothing written
    // loads, signed then unsigned
    localparam mem_op_t OP_LB   = 4'd1;
    localparam mem_op_t OP_LH   = 4'd2;
    localparam mem_op_t OP_LW   = 4'd3;
    localparam mem_op_t OP_LD   = 4'd4;
    localparam mem_op_t OP_LBU  = 4'd5;
    localparam mem_op_t OP_LHU  = 4'd6;
    localparam mem_op_t OP_LWU  = 4'd7;
    // stores
    localparam mem_op_t OP_SB   = 4'd8;
    localparam mem_op_t OP_SH   = 4'd9;
    localparam mem_op_t OP_SW   = 4'd10;
    localparam mem_op_t OP_SD   = 4'd11;
    // register writes that bypass memory
    localparam mem_op_t OP_ALU  = 4'd12;         // alu result
    localparam mem_op_t OP_LINK = 4'd13;         // pc + 4
    localparam mem_op_t OP_CSR  = 4'd14;         // old csr value on src2

    // ********************
    // byte lanes and ram
    // ********************

    typedef logic [7:0] byte_mask_t;             // one bit per byte lane
    typedef logic [2:0] byte_off_t;              // byte within a doubleword

    localparam int RAM_WORDS   = 64;             // doublewords
    localparam int RAM_IDX_LSB = 3;              // word index from addr[8:3]

    typedef logic [$clog2(RAM_WORDS)-1:0] ram_idx_t;

endpackage

//--- src/mem_stage_reg.sv
// execute to memory pipeline register, stalls on ready level
`timescale 1ns/10ps

module mem_stage_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ready_out,     // downstream can take the held item
    input  logic                   valid_in,
    input  rv_pkg::xword_t         pc_in,
    input  rv_pkg::inst_t          inst_in,
    input  mem_stage_pkg::mem_op_t op_in,
    input  rv_pkg::xword_t         alu_in,        // address for loads and stores
    input  rv_pkg::xword_t         src2_in,       // store data or csr old value
    output logic                   stage_valid,
    output rv_pkg::xword_t         stage_pc,
    output rv_pkg::inst_t          stage_inst,
    output mem_stage_pkg::mem_op_t stage_op,
    output rv_pkg::xword_t         stage_alu,
    output rv_pkg::xword_t         stage_src2
);

    import mem_stage_pkg::*;

    // ********************
    // stage register
    // ********************

    // single register between ex and mem
    // holds everything while ready_out is low
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
            stage_pc    <= '0;
            stage_inst  <= '0;
            stage_op    <= OP_NONE;
            stage_alu   <= '0;
            stage_src2  <= '0;
        end else if (ready_out) begin
            stage_valid <= valid_in;
            stage_pc    <= pc_in;
            stage_inst  <= inst_in;
            stage_op    <= op_in;
            stage_alu   <= alu_in;
            stage_src2  <= src2_in;
        end
        // else hold, the same item stays in mem
    end

endmodule

//--- src/store_format.sv
// store side: rs2 forwarding from wb, lane alignment, byte mask
`timescale 1ns/10ps

module store_format (
    input  logic                       stage_valid,
    input  rv_pkg::inst_t              stage_inst,
    input  mem_stage_pkg::mem_op_t     stage_op,
    input  rv_pkg::xword_t             stage_alu,     // store address
    input  rv_pkg::xword_t             stage_src2,    // store data from ex
    input  logic                       wb_valid,      // wb instruction writes wb_rd
    input  rv_pkg::reg_idx_t           wb_rd,
    input  rv_pkg::xword_t             wb_wdata,
    output logic                       ram_we,
    output mem_stage_pkg::ram_idx_t    ram_idx,
    output rv_pkg::xword_t             ram_wdata,
    output mem_stage_pkg::byte_mask_t  ram_wmask
);

    import rv_pkg::*;
    import mem_stage_pkg::*;

    reg_idx_t  rs2;
    logic      is_store;
    logic      fwd_hit;
    xword_t    src2_fwd;
    byte_off_t off;

    assign rs2 = stage_inst[RS2_LSB +: $bits(reg_idx_t)];
    assign off = stage_alu[$bits(byte_off_t)-1:0];

    always_comb begin
        case (stage_op)
            OP_SB, OP_SH, OP_SW, OP_SD: is_store = 1'b1;
            default:                    is_store = 1'b0;
        endcase
    end

    // ********************
    // rs2 forwarding
    // ********************

    // wb result not yet in the register file, x0 never forwards
    assign fwd_hit  = stage_valid && is_store && wb_valid && (rs2 != '0) && (wb_rd == rs2);
    assign src2_fwd = fwd_hit ? wb_wdata : stage_src2;

    // ********************
    // lane placement
    // ********************

    assign ram_we  = stage_valid && is_store;
    assign ram_idx = stage_alu[RAM_IDX_LSB +: $bits(ram_idx_t)];   // upper addr bits wrap

    always_comb begin
        ram_wdata = '0;
        ram_wmask = '0;
        case (stage_op)
            OP_SB: begin
                ram_wdata = xword_t'(src2_fwd[7:0]) << {off, 3'b000};
                ram_wmask = byte_mask_t'(8'h01) << off;
            end
            OP_SH: begin
                // a half at offset 7 would cross the doubleword so nothing is written
                if (off != 3'd7) begin
                    ram_wdata = xword_t'(src2_fwd[15:0]) << {off, 3'b000};
                    ram_wmask = byte_mask_t'(8'h03) << off;
                end
            end
            OP_SW: begin
                if (off[2]) begin                   // upper word
                    ram_wdata = {src2_fwd[31:0], 32'h0};
                    ram_wmask = 8'hf0;
                end else begin
                    ram_wdata = {32'h0, src2_fwd[31:0]};
                    ram_wmask = 8'h0f;
                end
            end
            OP_SD: begin
                ram_wdata = src2_fwd;
                ram_wmask = '1;                     // all eight lanes
            end
            default: begin
                ram_wdata = '0;
                ram_wmask = '0;
            end
        endcase
    end

endmodule

//--- src/data_ram.sv
// 64 doubleword data ram, byte masked sync write, async read
`timescale 1ns/10ps

module data_ram (
    input  logic                       clk,
    input  logic                       ram_we,
    input  mem_stage_pkg::ram_idx_t    ram_idx,     // write index
    input  rv_pkg::xword_t             ram_wdata,   // already lane aligned
    input  mem_stage_pkg::byte_mask_t  ram_wmask,
    input  mem_stage_pkg::ram_idx_t    rd_idx,      // read index
    output rv_pkg::xword_t             ram_rdata
);

    import rv_pkg::*;
    import mem_stage_pkg::*;

    xword_t mem [RAM_WORDS];                        // contents undefined until written

    // ********************
    // write port
    // ********************

    // only lanes with a mask bit change
    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int i = 0; i < $bits(byte_mask_t); i++) begin
                if (ram_wmask[i]) begin
                    mem[ram_idx][8*i +: 8] <= ram_wdata[8*i +: 8];
                end
            end
        end
    end

    // ********************
    // read port
    // ********************

    // combinational, a load right after a store sees the new bytes
    assign ram_rdata = mem[rd_idx];

endmodule

//--- src/load_writeback.sv
// load extraction and extension, register write back select, output gating
`timescale 1ns/10ps

module load_writeback (
    input  logic                    stage_valid,
    input  rv_pkg::xword_t          stage_pc,
    input  rv_pkg::inst_t           stage_inst,
    input  mem_stage_pkg::mem_op_t  stage_op,
    input  rv_pkg::xword_t          stage_alu,     // load address or alu result
    input  rv_pkg::xword_t          stage_src2,    // csr old value
    input  rv_pkg::xword_t          ram_rdata,
    output mem_stage_pkg::ram_idx_t rd_idx,
    output logic                    valid_out,
    output rv_pkg::xword_t          pc_out,
    output rv_pkg::inst_t           inst_out,
    output logic                    reg_wr_wen,
    output rv_pkg::reg_idx_t        reg_wr_id,
    output rv_pkg::xword_t          reg_wr_value
);

    import rv_pkg::*;
    import mem_stage_pkg::*;

    byte_off_t   off;
    xword_t      shifted;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_word;
    xword_t      ld_value;
    logic        wen;
    xword_t      wdata;

    assign rd_idx = stage_alu[RAM_IDX_LSB +: $bits(ram_idx_t)];
    assign off    = stage_alu[$bits(byte_off_t)-1:0];

    // ********************
    // load extraction
    // ********************

    assign shifted = ram_rdata >> {off, 3'b000};              // addressed byte to lane 0
    assign ld_byte = shifted[7:0];
    assign ld_half = (off == 3'd7) ? 16'h0 : shifted[15:0];   // crossing half reads zero
    assign ld_word = off[2] ? ram_rdata[63:32] : ram_rdata[31:0];

    always_comb begin
        case (stage_op)
            OP_LB:   ld_value = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            OP_LH:   ld_value = {{(XLEN-16){ld_half[15]}}, ld_half};
            OP_LW:   ld_value = {{(XLEN-32){ld_word[31]}}, ld_word};
            OP_LBU:  ld_value = xword_t'(ld_byte);
            OP_LHU:  ld_value = xword_t'(ld_half);
            OP_LWU:  ld_value = xword_t'(ld_word);
            OP_LD:   ld_value = ram_rdata;
            default: ld_value = '0;
        endcase
    end

    // ********************
    // write back select
    // ********************

    always_comb begin
        wen   = 1'b1;
        wdata = '0;
        case (stage_op)
            OP_LB, OP_LH, OP_LW, OP_LD,
            OP_LBU, OP_LHU, OP_LWU: wdata = ld_value;
            OP_ALU:                 wdata = stage_alu;
            OP_LINK:                wdata = stage_pc + INST_STEP;   // return address
            OP_CSR:                 wdata = stage_src2;
            default:                wen   = 1'b0;                   // stores and bubbles
        endcase
    end

    // everything reads zero when the stage is empty
    assign valid_out    = stage_valid;
    assign pc_out       = stage_valid ? stage_pc : '0;
    assign inst_out     = stage_valid ? stage_inst : '0;
    assign reg_wr_wen   = stage_valid && wen;
    assign reg_wr_id    = stage_valid ? stage_inst[RD_LSB +: $bits(reg_idx_t)] : '0;
    assign reg_wr_value = stage_valid ? wdata : '0;

endmodule

//--- src/mem_stage.sv
// memory stage top: stage register, store format, data ram, load and write back
`timescale 1ns/10ps

module mem_stage (
    input  logic                   clk,
    input  logic                   rst,
    // from execute
    input  logic                   valid_in,
    output logic                   ready_in,
    input  rv_pkg::xword_t         pc_in,
    input  rv_pkg::inst_t          inst_in,
    input  mem_stage_pkg::mem_op_t op_in,
    input  rv_pkg::xword_t         alu_in,
    input  rv_pkg::xword_t         src2_in,
    // to and from write back
    output logic                   valid_out,
    input  logic                   ready_out,
    output rv_pkg::xword_t         pc_out,
    output rv_pkg::inst_t          inst_out,
    input  logic                   wb_valid,
    input  rv_pkg::reg_idx_t       wb_rd,
    input  rv_pkg::xword_t         wb_wdata,
    // register file write
    output logic                   reg_wr_wen,
    output rv_pkg::reg_idx_t       reg_wr_id,
    output rv_pkg::xword_t         reg_wr_value
);

    import rv_pkg::*;
    import mem_stage_pkg::*;

    logic       stage_valid;
    xword_t     stage_pc;
    inst_t      stage_inst;
    mem_op_t    stage_op;
    xword_t     stage_alu;
    xword_t     stage_src2;
    logic       ram_we;
    ram_idx_t   ram_idx;
    xword_t     ram_wdata;
    byte_mask_t ram_wmask;
    ram_idx_t   rd_idx;
    xword_t     ram_rdata;

    assign ready_in = ready_out;                   // no internal stall source

    mem_stage_reg u_stage_reg (
        .clk, .rst, .ready_out, .valid_in, .pc_in, .inst_in, .op_in, .alu_in, .src2_in,
        .stage_valid, .stage_pc, .stage_inst, .stage_op, .stage_alu, .stage_src2
    );

    store_format u_store_format (
        .stage_valid, .stage_inst, .stage_op, .stage_alu, .stage_src2,
        .wb_valid, .wb_rd, .wb_wdata,
        .ram_we, .ram_idx, .ram_wdata, .ram_wmask
    );

    data_ram u_data_ram (
        .clk, .ram_we, .ram_idx, .ram_wdata, .ram_wmask, .rd_idx, .ram_rdata
    );

    load_writeback u_load_writeback (
        .stage_valid, .stage_pc, .stage_inst, .stage_op, .stage_alu, .stage_src2,
        .ram_rdata, .rd_idx, .valid_out, .pc_out, .inst_out,
        .reg_wr_wen, .reg_wr_id, .reg_wr_value
    );

endmodule

//--- tb/mem_stage_tb.sv
// memory stage testbench: stimulus table, reference model, checker, watchdog
`timescale 1ns/10ps

module mem_stage_tb;

    import rv_pkg::*;
    import mem_stage_pkg::*;

    localparam int MAX_ROWS = 40;

    logic clk, rst, valid_in, ready_in, ready_out, wb_valid, valid_out, reg_wr_wen;
    xword_t pc_in, alu_in, src2_in, wb_wdata, pc_out, reg_wr_value;
    inst_t inst_in, inst_out;
    mem_op_t op_in;
    reg_idx_t wb_rd, reg_wr_id;

    // table: stimulus plus expected outputs
    string    t_name [MAX_ROWS];
    logic     t_valid [MAX_ROWS];
    mem_op_t  t_op [MAX_ROWS];
    xword_t   t_addr [MAX_ROWS], t_src2 [MAX_ROWS], t_wdata [MAX_ROWS], e_value [MAX_ROWS];
    reg_idx_t t_rd [MAX_ROWS], t_rs2 [MAX_ROWS], t_wrd [MAX_ROWS];
    logic     t_wbv [MAX_ROWS], e_wen [MAX_ROWS];

    xword_t model_ram [64];                        // reference copy of the data ram
    int n_rows = 0, n_pass = 0, n_fail = 0, errs = 0;
    logic table_done = 1'b0;                       // table built, row count final
    logic [31:0] seed = 32'h2b8d_4933;
    xword_t d0, d1;

    mem_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ********************
    // reference model
    // ********************

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic xword_t rand64();
        logic [31:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    // pc given to table row i
    function automatic xword_t row_pc(input int i);
        return 64'h1000 + 64'(4 * i);
    endfunction

    // r-type word carrying the rd and rs2 fields
    function automatic inst_t encode_inst(input reg_idx_t rd, input reg_idx_t rs2);
        return {7'h0, rs2, 5'h0, 3'h0, rd, 7'h33};
    endfunction

    function automatic xword_t load_ref(xword_t w, mem_op_t op, byte_off_t off);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] wd;
        b  = w[8*off +: 8];
        h  = (off == 3'd7) ? 16'h0 : {w[8*byte_off_t'(off + 3'd1) +: 8], b};  // no crossing
        wd = off[2] ? w[63:32] : w[31:0];
        case (op)
            OP_LB:   return {{56{b[7]}}, b};
            OP_LH:   return {{48{h[15]}}, h};
            OP_LW:   return {{32{wd[31]}}, wd};
            OP_LBU:  return {56'h0, b};
            OP_LHU:  return {48'h0, h};
            OP_LWU:  return {32'h0, wd};
            OP_LD:   return w;
            default: return '0;
        endcase
    endfunction

    // appends a row, works out its expected result and updates the model ram
    task automatic add_row(input string name, input mem_op_t op, input xword_t addr, src2,
                           input reg_idx_t rd, rs2, input logic wbv, input reg_idx_t wrd,
                           input xword_t wdata);
        int k;
        xword_t eff;
        byte_off_t off;
        logic [5:0] idx;
        k = n_rows;
        off = addr[2:0];
        idx = addr[8:3];                           // higher bits wrap
        t_name[k]  = name;
        t_valid[k] = 1'b1;
        t_op[k]    = op;
        t_addr[k]  = addr;
        t_src2[k]  = src2;
        t_rd[k]    = rd;
        t_rs2[k]   = rs2;
        t_wbv[k]   = wbv;
        t_wrd[k]   = wrd;
        t_wdata[k] = wdata;
        e_wen[k] = !(op inside {OP_NONE, OP_SB, OP_SH, OP_SW, OP_SD});
        case (op)
            OP_ALU:  e_value[k] = addr;
            OP_LINK: e_value[k] = row_pc(k) + 64'd4;   // pc + 4
            OP_CSR:  e_value[k] = src2;
            default: e_value[k] = load_ref(model_ram[idx], op, off);
        endcase
        eff = (wbv && rs2 != 5'd0 && wrd == rs2) ? wdata : src2;    // wb forwarding
        for (int j = 0; j < 8; j++) begin
            case (op)
                OP_SB: if (byte_off_t'(j) == off) model_ram[idx][8*j +: 8] = eff[7:0];
                OP_SH: if (off != 3'd7 && (byte_off_t'(j) == off || byte_off_t'(j) == off + 3'd1))
                    model_ram[idx][8*j +: 8] = eff[8*(byte_off_t'(j) - off) +: 8];
                OP_SW: if ((j / 4) == int'(off[2])) model_ram[idx][8*j +: 8] = eff[8*(j%4) +: 8];
                OP_SD: model_ram[idx][8*j +: 8] = eff[8*j +: 8];
                default: ;
            endcase
        end
        n_rows++;
    endtask

    // ********************
    // drive and check
    // ********************

    task automatic check(input string sig, input xword_t act, input xword_t exp);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h got %h", $time, sig, exp, act);
            errs++;
        end
    endtask

    task automatic report_row(input string name);
        if (errs == 0) begin
            n_pass++;
            $display("PASS %s", name);
        end else begin
            n_fail++;
            $display("FAIL %s (%0d mismatches)", name, errs);
        end
        errs = 0;
    endtask

    task automatic drive_exec(input logic v, input mem_op_t op, input xword_t pc, alu, src2,
                              input reg_idx_t rd, rs2);
        valid_in = v;
        op_in    = op;
        pc_in    = pc;
        alu_in   = alu;
        src2_in  = src2;
        inst_in  = encode_inst(rd, rs2);
    endtask

    task automatic check_out(input logic v, input xword_t pc, input inst_t inst, input logic wen,
                             input reg_idx_t rd, input xword_t val);
        check("valid_out", xword_t'(valid_out), xword_t'(v));
        check("pc_out", pc_out, v ? pc : 64'h0);                 // empty stage reads zero
        check("inst_out", xword_t'(inst_out), xword_t'(v ? inst : 32'h0));
        check("reg_wr_wen", xword_t'(reg_wr_wen), xword_t'(wen));
        if (wen) begin
            check("reg_wr_id", xword_t'(reg_wr_id), xword_t'(rd));
            check("reg_wr_value", reg_wr_value, val);
        end
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_done);
        #((n_rows + 10) * 40 * 4);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        ready_out = 1'b1;
        wb_valid  = 1'b0;
        wb_rd     = '0;
        wb_wdata  = '0;
        drive_exec(1'b0, OP_NONE, '0, '0, '0, '0, '0);
        d0 = rand64() | 64'h8080_8080_8080_8080;   // negative in every lane
        d1 = rand64();
        add_row("sd_base", OP_SD, 64'h10, d0, 5'd0, 5'd5, 1'b0, 5'd0, '0);
        add_row("lb_off0", OP_LB, 64'h10, '0, 5'd1, 5'd0, 1'b0, 5'd0, '0);
        add_row("lb_off3", OP_LB, 64'h13, '0, 5'd1, 5'd0, 1'b0, 5'd0, '0);
        add_row("lbu_off3", OP_LBU, 64'h13, '0, 5'd2, 5'd0, 1'b0, 5'd0, '0);
        add_row("lh_off2", OP_LH, 64'h12, '0, 5'd3, 5'd0, 1'b0, 5'd0, '0);
        add_row("lh_off7", OP_LH, 64'h17, '0, 5'd3, 5'd0, 1'b0, 5'd0, '0);
        add_row("lhu_off6", OP_LHU, 64'h16, '0, 5'd4, 5'd0, 1'b0, 5'd0, '0);
        add_row("lw_off0", OP_LW, 64'h10, '0, 5'd5, 5'd0, 1'b0, 5'd0, '0);
        add_row("lw_off4", OP_LW, 64'h14, '0, 5'd5, 5'd0, 1'b0, 5'd0, '0);
        add_row("lwu_off4", OP_LWU, 64'h14, '0, 5'd6, 5'd0, 1'b0, 5'd0, '0);
        add_row("ld_base", OP_LD, 64'h10, '0, 5'd7, 5'd0, 1'b0, 5'd0, '0);
        // lane merge into one doubleword, each store on lanes of its own
        add_row("sd_merge", OP_SD, 64'h28, d1, 5'd0, 5'd5, 1'b0, 5'd0, '0);
        add_row("sb_off6", OP_SB, 64'h2e, rand64(), 5'd0, 5'd5, 1'b0, 5'd0, '0);
        add_row("sh_off4", OP_SH, 64'h2c, rand64(), 5'd0, 5'd5, 1'b0, 5'd0, '0);
        add_row("sh_off7", OP_SH, 64'h2f, rand64(), 5'd0, 5'd5, 1'b0, 5'd0, '0);
        add_row("sw_low", OP_SW, 64'h28, rand64(), 5'd0, 5'd5, 1'b0, 5'd0, '0);
        add_row("ld_merge", OP_LD, 64'h28, '0, 5'd8, 5'd0, 1'b0, 5'd0, '0);
        add_row("ld_wrap", OP_LD, 64'h228, '0, 5'd8, 5'd0, 1'b0, 5'd0, '0);
        // forwarding of rs2 from write back
        add_row("sd_fwd", OP_SD, 64'h30, rand64(), 5'd0, 5'd7, 1'b1, 5'd7, rand64());
        add_row("ld_fwd", OP_LD, 64'h30, '0, 5'd9, 5'd0, 1'b0, 5'd0, '0);
        add_row("sd_rs2_x0", OP_SD, 64'h38, rand64(), 5'd0, 5'd0, 1'b1, 5'd0, rand64());
        add_row("ld_rs2_x0", OP_LD, 64'h38, '0, 5'd9, 5'd0, 1'b0, 5'd0, '0);
        add_row("sd_wb_idle", OP_SD, 64'h40, rand64(), 5'd0, 5'd9, 1'b0, 5'd9, rand64());
        add_row("ld_wb_idle", OP_LD, 64'h40, '0, 5'd9, 5'd0, 1'b0, 5'd0, '0);
        // write back select
        add_row("alu", OP_ALU, rand64(), '0, 5'd10, 5'd0, 1'b0, 5'd0, '0);
        add_row("link", OP_LINK, '0, '0, 5'd1, 5'd0, 1'b0, 5'd0, '0);
        add_row("csr", OP_CSR, '0, rand64(), 5'd11, 5'd0, 1'b0, 5'd0, '0);
        add_row("none", OP_NONE, '0, '0, 5'd12, 5'd0, 1'b0, 5'd0, '0);
        add_row("bubble", OP_ALU, '0, '0, 5'd13, 5'd0, 1'b0, 5'd0, '0);
        t_valid[n_rows-1] = 1'b0;
        e_wen[n_rows-1]   = 1'b0;
        table_done = 1'b1;

        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        #37;
        check_out(1'b0, '0, '0, 1'b0, '0, '0);
        report_row("reset");

        // row i enters at the next edge, row i-1 sits in the stage
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            #2;
            if (i < n_rows)
                drive_exec(t_valid[i], t_op[i], row_pc(i), t_addr[i], t_src2[i],
                           t_rd[i], t_rs2[i]);
            else
                drive_exec(1'b0, OP_NONE, '0, '0, '0, '0, '0);
            wb_valid = (i > 0) ? t_wbv[i-1] : 1'b0;
            wb_rd    = (i > 0) ? t_wrd[i-1] : '0;
            wb_wdata = (i > 0) ? t_wdata[i-1] : '0;
            #37;
            if (i > 0) begin
                check_out(t_valid[i-1], row_pc(i-1), encode_inst(t_rd[i-1], t_rs2[i-1]),
                          e_wen[i-1], t_rd[i-1], e_value[i-1]);
                report_row(t_name[i-1]);
            end
        end

        // ********************
        // back-pressure
        // ********************
        d0 = rand64();
        @(posedge clk);
        #2 drive_exec(1'b1, OP_ALU, 64'h2000, d0, '0, 5'd4, 5'd0);
        wb_valid = 1'b0;
        @(posedge clk);
        #2 ready_out = 1'b0;
        drive_exec(1'b1, OP_ALU, 64'h2004, 64'h55, '0, 5'd6, 5'd0);
        for (int k = 0; k < 3; k++) begin
            #37;
            check("ready_in", xword_t'(ready_in), 64'd0);
            // still the held item
            check_out(1'b1, 64'h2000, encode_inst(5'd4, 5'd0), 1'b1, 5'd4, d0);
            @(posedge clk);
            #2;
            if (k < 2)
                alu_in = rand64();                 // ignored while stalled
            else begin
                ready_out = 1'b1;
                alu_in = 64'h55;
            end
        end
        #37;
        check("ready_in", xword_t'(ready_in), 64'd1);
        check_out(1'b1, 64'h2000, encode_inst(5'd4, 5'd0), 1'b1, 5'd4, d0);
        @(posedge clk);
        #2 drive_exec(1'b0, OP_NONE, '0, '0, '0, '0, '0);
        #37;
        check_out(1'b1, 64'h2004, encode_inst(5'd6, 5'd0), 1'b1, 5'd6, 64'h55);
        report_row("back_pressure");

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- filelist.f
src/rv_pkg.sv
src/mem_stage_pkg.sv
src/mem_stage_reg.sv
src/store_format.sv
src/data_ram.sv
src/load_writeback.sv
src/mem_stage.sv
tb/mem_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module mem_stage_tb -o mem_stage_sim
./obj_dir/mem_stage_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run passed"
else
    echo "run failed"
    exit 1
fi
